// File: source/usb_bus_pkg.sv
package usb_bus_pkg;

   ////////////////////////////////////////////////////////////
   // chip side pins
   ////////////////////////////////////////////////////////////

   // raw parallel bus from the usb chip, all asynchronous to clk_usb
   typedef struct packed {
      logic [7:0] addr;   // register address, valid in address phase
      logic [7:0] din;    // write data from host
      logic       rdn;    // read strobe, active low
      logic       wrn;    // write strobe, active low
      logic       cen;    // chip enable, active low
      logic       alen;   // low = address phase, high = data phase
   } usb_pins_t;

   ////////////////////////////////////////////////////////////
   // register side strobes
   ////////////////////////////////////////////////////////////

   // bridge to register bank
   // read data must be on reg_datai one cycle after read rises
   typedef struct packed {
      logic [7:0] address;   // registered chip address
      logic [7:0] datao;     // captured write byte
      logic       read;      // high while host holds rdn low
      logic       write;     // single cycle pulse, datao valid
   } reg_access_t;

endpackage

// File: source/reg_map_pkg.sv
package reg_map_pkg;

   ////////////////////////////////////////////////////////////
   // register addresses
   ////////////////////////////////////////////////////////////

   typedef enum logic [7:0] {
      reg_id         = 8'h00,   // read only identification byte
      reg_scratch    = 8'h01,   // 4 byte scratch, byte count selects
      reg_gen_ctrl   = 8'h02,   // generator control byte
      reg_gen_step   = 8'h03,   // generator increment
      reg_fifo_count = 8'h04,   // words waiting in sample fifo
      reg_fifo_data  = 8'h05    // fifo word, lsb first
   } reg_addr_e;

   // value returned on reg_id
   localparam logic [7:0] id_value = 8'h5A;

   ////////////////////////////////////////////////////////////
   // control and data types
   ////////////////////////////////////////////////////////////

   // generator control byte, bit 0 is enable
   typedef struct packed {
      logic [4:0] reserved;    // stored and read back only
      logic       clear;       // self clearing accumulator reset
      logic       fast_read;   // keep bus driven on fifo reads
      logic       enable;      // generator runs
   } gen_ctrl_t;

   // one captured sample word
   typedef logic [31:0] sample_t;

endpackage

// File: source/usb_reg_main.sv
`timescale 1ns/1ps

module usb_reg_main #(
   parameter int byte_count_width = 7
) (
   input  logic                          clk_usb,
   input  logic                          reset,
   input  usb_bus_pkg::usb_pins_t        bus,              // async chip pins
   input  logic                          fast_fifo_read,   // from bank
   input  logic [7:0]                    reg_datai,        // read data from bank
   output logic [7:0]                    dout,
   output logic                          isout,            // output enable
   output usb_bus_pkg::reg_access_t      access,
   output logic [byte_count_width-1:0]   reg_bytecnt
);

   logic       wrn_rs;             // first sample of wrn
   logic       wrn_rs_dly;         // second sample of wrn
   logic       reg_write;          // write pulse
   logic       reg_write_dly;      // bumps byte count after write
   logic       isout_r;            // registered ~rdn
   logic       isout_r_dly;        // one more cycle of ~rdn
   logic       alen_r;             // registered phase flag
   logic       fast_fifo_read_r;   // for rising edge detect
   logic       drive_data_out;     // fast read bus hold
   logic [7:0] reg_address;
   logic [7:0] reg_datao;
   logic       read_done;

   ////////////////////////////////////////////////////////////
   // strobe sampling
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         wrn_rs           <= 1'b1;   // idle high, no false pulse out of reset
         wrn_rs_dly       <= 1'b1;
         reg_write        <= 1'b0;
         reg_write_dly    <= 1'b0;
         isout_r          <= 1'b0;
         isout_r_dly      <= 1'b0;
         alen_r           <= 1'b0;
         fast_fifo_read_r <= 1'b0;
         drive_data_out   <= 1'b0;
      end else begin
         wrn_rs        <= bus.wrn;
         wrn_rs_dly    <= wrn_rs;
         reg_write     <= wrn_rs & ~wrn_rs_dly;   // rising wrn
         reg_write_dly <= reg_write;

         isout_r     <= ~bus.rdn;
         isout_r_dly <= isout_r;

         alen_r           <= bus.alen;
         fast_fifo_read_r <= fast_fifo_read;

         // grab the bus when a fast read starts
         // let go only once the host begins a write
         if (!bus.wrn)
            drive_data_out <= 1'b0;
         else if (fast_fifo_read && !fast_fifo_read_r)
            drive_data_out <= 1'b1;
      end
   end

   // address and write data
   always_ff @(posedge clk_usb) begin
      reg_address <= bus.addr;
      if (!bus.cen && !wrn_rs)
         reg_datao <= bus.din;   // last capture is the byte before wrn rose
   end

   ////////////////////////////////////////////////////////////
   // byte counter
   ////////////////////////////////////////////////////////////

   assign read_done = isout_r_dly & ~isout_r;   // rdn just released

   always_ff @(posedge clk_usb) begin
      if (reset)
         reg_bytecnt <= '0;
      else if (!alen_r)
         reg_bytecnt <= '0;                // new address phase
      else if (read_done || reg_write_dly)
         reg_bytecnt <= reg_bytecnt + 1'b1; // wraps, fifo only looks at mod 4
   end

   ////////////////////////////////////////////////////////////
   // outputs
   ////////////////////////////////////////////////////////////

   assign dout = reg_datai;

   // hold the drivers one cycle past rdn release
   assign isout = isout_r | isout_r_dly | (drive_data_out & bus.wrn);

   assign access.address = reg_address;
   assign access.datao   = reg_datao;
   assign access.read    = isout_r;
   assign access.write   = reg_write;

endmodule

// File: source/reg_bank.sv
`timescale 1ns/1ps

module reg_bank #(
   parameter int byte_count_width = 7,
   parameter int fifo_depth       = 16
) (
   input  logic                              clk_usb,
   input  logic                              reset,
   input  usb_bus_pkg::reg_access_t          access,
   input  logic [byte_count_width-1:0]       reg_bytecnt,
   output logic [7:0]                        reg_datai,
   output logic                              fast_fifo_read,
   output logic                              gen_enable,
   output logic                              gen_clear,
   output logic [7:0]                        gen_step,
   input  reg_map_pkg::sample_t              fifo_word,     // oldest fifo entry
   input  logic [$clog2(fifo_depth):0]       fifo_count,
   output logic                              fifo_pop
);

   reg_map_pkg::reg_addr_e addr;
   reg_map_pkg::gen_ctrl_t ctrl;
   logic [3:0][7:0]        scratch;
   logic [1:0]             byte_sel;     // byte count mod 4
   logic                   read_d;       // for end of read detect
   logic [7:0]             count_byte;
   logic [7:0]             fifo_byte;

   assign addr     = reg_map_pkg::reg_addr_e'(access.address);
   assign byte_sel = reg_bytecnt[1:0];

   ////////////////////////////////////////////////////////////
   // register writes
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         scratch  <= '0;
         ctrl     <= '0;       // generator off
         gen_step <= 8'd1;
      end else begin
         if (ctrl.clear)
            ctrl.clear <= 1'b0;   // one cycle only
         if (access.write) begin
            case (addr)
               reg_map_pkg::reg_scratch:  scratch[byte_sel] <= access.datao;
               reg_map_pkg::reg_gen_ctrl: ctrl <= reg_map_pkg::gen_ctrl_t'(access.datao);
               reg_map_pkg::reg_gen_step: gen_step <= access.datao;
               default: ;                  // read only or unmapped
            endcase
         end
      end
   end

   always_ff @(posedge clk_usb) begin
      if (reset)
         read_d <= 1'b0;
      else
         read_d <= access.read;
   end

   assign gen_enable = ctrl.enable;
   assign gen_clear  = ctrl.clear;

   ////////////////////////////////////////////////////////////
   // read path
   ////////////////////////////////////////////////////////////

   assign count_byte = 8'(fifo_count);                 // zero extend
   assign fifo_byte  = fifo_word[8*byte_sel +: 8];     // lsb first

   // combinational on address and byte count
   always_comb begin
      case (addr)
         reg_map_pkg::reg_id:         reg_datai = reg_map_pkg::id_value;
         reg_map_pkg::reg_scratch:    reg_datai = scratch[byte_sel];
         reg_map_pkg::reg_gen_ctrl:   reg_datai = ctrl;
         reg_map_pkg::reg_gen_step:   reg_datai = gen_step;
         reg_map_pkg::reg_fifo_count: reg_datai = count_byte;
         reg_map_pkg::reg_fifo_data:  reg_datai = fifo_byte;
         default:                     reg_datai = 8'h00;
      endcase
   end

   // pop once the host has taken the top byte of the word
   // same edge the bridge advances the byte count
   assign fifo_pop = read_d & ~access.read
                   & (addr == reg_map_pkg::reg_fifo_data)
                   & (byte_sel == 2'd3);

   // bridge keeps the bus driven between fast fifo reads
   assign fast_fifo_read = (addr == reg_map_pkg::reg_fifo_data) & ctrl.fast_read;

endmodule

// File: source/sample_gen.sv
`timescale 1ns/1ps

module sample_gen (
   input  logic                 clk_usb,
   input  logic                 reset,
   input  logic                 enable,
   input  logic                 clear,
   input  logic [7:0]           step,
   output reg_map_pkg::sample_t sample,
   output logic                 valid,
   input  logic                 ready
);

   typedef enum logic {
      idle,
      run
   } gen_state_e;

   gen_state_e           state;
   reg_map_pkg::sample_t acc;   // next value to offer

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         state <= idle;
         acc   <= '0;
      end else begin
         case (state)
            idle: if (enable) state <= run;
            run:  if (!enable) state <= idle;
            default: state <= idle;
         endcase

         if (clear)
            acc <= '0;                                    // restart sequence
         else if (valid && ready)
            acc <= acc + reg_map_pkg::sample_t'(step);    // accepted, advance
      end
   end

   assign valid  = (state == run);
   assign sample = acc;   // held while stalled

endmodule

// File: source/sample_fifo.sv
`timescale 1ns/1ps

module sample_fifo #(
   parameter int fifo_depth = 16   // power of two
) (
   input  logic                        clk_usb,
   input  logic                        reset,
   input  reg_map_pkg::sample_t        push_data,
   input  logic                        push_valid,
   output logic                        push_ready,
   input  logic                        pop,
   output reg_map_pkg::sample_t        head,
   output logic [$clog2(fifo_depth):0] count
);

   localparam int ptr_width = $clog2(fifo_depth);
   localparam logic [ptr_width:0] full_count = (ptr_width + 1)'(fifo_depth);

   reg_map_pkg::sample_t mem [fifo_depth];
   logic [ptr_width-1:0] wr_ptr;
   logic [ptr_width-1:0] rd_ptr;
   logic                 do_push;
   logic                 do_pop;

   ////////////////////////////////////////////////////////////
   // handshake
   ////////////////////////////////////////////////////////////

   assign push_ready = (count != full_count);   // low when full
   assign do_push    = push_valid & push_ready;
   assign do_pop     = pop & (count != '0);     // empty pop dropped

   ////////////////////////////////////////////////////////////
   // pointers and count
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ;                 // none or both
         endcase
      end
   end

   // storage
   always_ff @(posedge clk_usb) begin
      if (do_push)
         mem[wr_ptr] <= push_data;
   end

   // oldest word, straight off the array
   assign head = mem[rd_ptr];

endmodule

// File: source/usb_reg_top.sv
`timescale 1ns/1ps

module usb_reg_top #(
   parameter int byte_count_width = 7,
   parameter int fifo_depth       = 16
) (
   input  logic                   clk_usb,
   input  logic                   reset,
   input  usb_bus_pkg::usb_pins_t bus,
   output logic [7:0]             dout,
   output logic                   isout
);

   usb_bus_pkg::reg_access_t      access;
   logic [byte_count_width-1:0]   reg_bytecnt;
   logic [7:0]                    reg_datai;
   logic                          fast_fifo_read;

   // generator side
   logic                          gen_enable;
   logic                          gen_clear;
   logic [7:0]                    gen_step;
   reg_map_pkg::sample_t          sample;
   logic                          sample_valid;
   logic                          sample_ready;

   // fifo side
   reg_map_pkg::sample_t          fifo_word;
   logic [$clog2(fifo_depth):0]   fifo_count;
   logic                          fifo_pop;

   ////////////////////////////////////////////////////////////
   // chip bus bridge and registers
   ////////////////////////////////////////////////////////////

   usb_reg_main #(
      .byte_count_width (byte_count_width)
   ) u_usb_reg_main (
      .clk_usb        (clk_usb),
      .reset          (reset),
      .bus            (bus),
      .fast_fifo_read (fast_fifo_read),
      .reg_datai      (reg_datai),
      .dout           (dout),
      .isout          (isout),
      .access         (access),
      .reg_bytecnt    (reg_bytecnt)
   );

   reg_bank #(
      .byte_count_width (byte_count_width),
      .fifo_depth       (fifo_depth)
   ) u_reg_bank (
      .clk_usb        (clk_usb),
      .reset          (reset),
      .access         (access),
      .reg_bytecnt    (reg_bytecnt),
      .reg_datai      (reg_datai),
      .fast_fifo_read (fast_fifo_read),
      .gen_enable     (gen_enable),
      .gen_clear      (gen_clear),
      .gen_step       (gen_step),
      .fifo_word      (fifo_word),
      .fifo_count     (fifo_count),
      .fifo_pop       (fifo_pop)
   );

   ////////////////////////////////////////////////////////////
   // sample path
   ////////////////////////////////////////////////////////////

   sample_gen u_sample_gen (
      .clk_usb (clk_usb),
      .reset   (reset),
      .enable  (gen_enable),
      .clear   (gen_clear),
      .step    (gen_step),
      .sample  (sample),
      .valid   (sample_valid),
      .ready   (sample_ready)   // low while fifo full
   );

   sample_fifo #(
      .fifo_depth (fifo_depth)
   ) u_sample_fifo (
      .clk_usb    (clk_usb),
      .reset      (reset),
      .push_data  (sample),
      .push_valid (sample_valid),
      .push_ready (sample_ready),
      .pop        (fifo_pop),
      .head       (fifo_word),
      .count      (fifo_count)
   );

endmodule

// File: dv/usb_bus_tasks.svh
////////////////////////////////////////////////////////////
// host side bus cycles
////////////////////////////////////////////////////////////

// alen low long enough for the byte count to clear
task automatic set_address(input logic [7:0] addr);
   @(negedge clk_usb);
   bus.alen = 1'b0;
   bus.addr = addr;
   repeat (3) @(negedge clk_usb);
   bus.alen = 1'b1;                 // data phase
   repeat (2) @(negedge clk_usb);
endtask

task automatic bus_write(input logic [7:0] data);
   @(negedge clk_usb);
   bus.din = data;
   bus.cen = 1'b0;
   bus.wrn = 1'b0;
   repeat (3) @(negedge clk_usb);
   bus.wrn = 1'b1;                  // write pulse follows this edge
   @(negedge clk_usb);
   bus.cen = 1'b1;
   repeat (4) @(negedge clk_usb);   // register written, byte count bumped
endtask

task automatic bus_read(output logic [7:0] data, output logic drive);
   @(negedge clk_usb);
   bus.cen = 1'b0;
   bus.rdn = 1'b0;
   repeat (4) @(negedge clk_usb);   // host holds rdn 4 cycles
   data    = dout;
   drive   = isout;
   bus.rdn = 1'b1;
   bus.cen = 1'b1;
   repeat (3) @(negedge clk_usb);   // count and fifo pop on second edge
endtask

// poll reg_fifo_count, never above depth
task automatic wait_fifo_count(input logic [7:0] target);
   logic [7:0] level;
   logic       drive;
   int         tries;
   level = 8'hFF;
   tries = 0;
   while (level != target) begin
      if (tries == poll_limit) begin
         timeout_fail($sformatf("fifo count never reached %0d", target));
      end else begin
         bus_read(level, drive);
         check_value(8'(drive), 8'd1, "isout during count read");
         check_value(8'(level > depth_byte), 8'd0, "fifo count above depth");
         tries++;
      end
   end
endtask

////////////////////////////////////////////////////////////
// checks
////////////////////////////////////////////////////////////

task automatic check_value(input logic [7:0] got, input logic [7:0] expected,
                           input string what);
   if (got !== expected) begin
      $display("CHECK FAILED at %0t: %s, got %02h expected %02h", $time, what, got, expected);
      $display("Test failed");
      $fatal(1, "stopped on first mismatch");
   end
endtask

task automatic timeout_fail(input string what);
   $display("timeout at %0t: %s", $time, what);
   $display("Test failed");
   $fatal(1, "stopped on timeout");
endtask

// File: dv/usb_reg_tb.sv
`timescale 1ns/1ps

module usb_reg_tb;

   localparam int         fifo_depth  = 16;
   localparam int         gen_step    = 3;       // step for the sequence checks
   localparam int         poll_limit  = 200;     // count reads before giving up
   localparam logic [7:0] depth_byte  = 8'(fifo_depth);
   localparam logic [7:0] ctrl_enable = 8'h01;   // control bit 0
   localparam logic [7:0] ctrl_fast   = 8'h02;   // bit 1, hold bus on fifo reads
   localparam logic [7:0] ctrl_clear  = 8'h04;   // bit 2, accumulator to zero

   typedef enum logic [1:0] {
      op_write,
      op_read,    // data = isout expected after rdn rises
      op_poll     // read fifo count until it equals expected
   } op_e;

   typedef struct packed {
      op_e        op;
      logic [7:0] addr;
      logic [7:0] idx;        // byte count of the access, 0 opens a new phase
      logic [7:0] data;
      logic [7:0] expected;
   } step_t;

   logic                   clk_usb;
   logic                   reset;
   usb_bus_pkg::usb_pins_t bus;
   logic [7:0]             dout;
   logic                   isout;
   step_t                  steps[$];
   logic [7:0]             got;
   logic                   oe;

   usb_reg_top #(
      .byte_count_width (7),
      .fifo_depth       (fifo_depth)
   ) u_usb_reg_top (
      .clk_usb (clk_usb),
      .reset   (reset),
      .bus     (bus),
      .dout    (dout),
      .isout   (isout)
   );

   `include "usb_bus_tasks.svh"

   ////////////////////////////////////////////////////////////
   // stimulus table
   ////////////////////////////////////////////////////////////

   function automatic void add_step(input op_e op, input logic [7:0] addr, input int idx,
                                    input logic [7:0] data, input logic [7:0] expected);
      step_t s;
      s.op       = op;
      s.addr     = addr;
      s.idx      = 8'(idx);
      s.data     = data;
      s.expected = expected;
      steps.push_back(s);
   endfunction

   // byte i of the k-th generator word, lsb first
   function automatic logic [7:0] word_byte(input int k, input int i);
      logic [31:0] word;
      word = 32'(gen_step * k);
      return word[8*i +: 8];
   endfunction

   function automatic void queue_word_read(input int k, input logic [7:0] hold);
      int i;
      for (i = 0; i < 4; i++)
         add_step(op_read, reg_map_pkg::reg_fifo_data, i, hold, word_byte(k, i));
   endfunction

   function automatic void build_table();
      logic [7:0] scratch_data [4];
      int         i;
      int         k;
      add_step(op_read, reg_map_pkg::reg_id, 0, 8'd0, reg_map_pkg::id_value);
      for (i = 0; i < 4; i++) begin             // one phase of writes
         scratch_data[i] = 8'($urandom());
         add_step(op_write, reg_map_pkg::reg_scratch, i, scratch_data[i], 8'd0);
      end
      for (i = 0; i < 4; i++)                   // new phase, same order back
         add_step(op_read, reg_map_pkg::reg_scratch, i, 8'd0, scratch_data[i]);
      add_step(op_write, reg_map_pkg::reg_gen_step, 0, 8'(gen_step), 8'd0);
      add_step(op_write, reg_map_pkg::reg_gen_ctrl, 0, ctrl_enable, 8'd0);
      add_step(op_poll, reg_map_pkg::reg_fifo_count, 0, 8'd0, depth_byte);
      // generator off so each pop shows in the count
      add_step(op_write, reg_map_pkg::reg_gen_ctrl, 0, 8'h00, 8'd0);
      for (k = 0; k < 2; k++) begin
         queue_word_read(k, 8'd0);
         add_step(op_poll, reg_map_pkg::reg_fifo_count, 0, 8'd0, depth_byte - 8'(k + 1));
      end
      add_step(op_write, reg_map_pkg::reg_gen_ctrl, 0, ctrl_enable, 8'd0);
      add_step(op_poll, reg_map_pkg::reg_fifo_count, 0, 8'd0, depth_byte);
      for (k = 2; k < 6; k++)
         queue_word_read(k, 8'd0);              // refilled behind each word
      // clear with generator off, drained words keep the old sequence
      add_step(op_write, reg_map_pkg::reg_gen_ctrl, 0, ctrl_clear, 8'd0);
      for (k = 6; k < 6 + fifo_depth; k++)
         queue_word_read(k, 8'd0);
      add_step(op_poll, reg_map_pkg::reg_fifo_count, 0, 8'd0, 8'd0);
      add_step(op_write, reg_map_pkg::reg_gen_ctrl, 0, ctrl_enable | ctrl_fast, 8'd0);
      add_step(op_poll, reg_map_pkg::reg_fifo_count, 0, 8'd0, depth_byte);
      for (k = 0; k < 2; k++)
         queue_word_read(k, 8'd1);              // restarted at 0, bus held
      add_step(op_write, reg_map_pkg::reg_gen_ctrl, 0, 8'h00, 8'd0);   // write ends hold
   endfunction

   initial begin
      clk_usb = 1'b0;
      forever #2 clk_usb = ~clk_usb;   // 250 MHz
   end

   ////////////////////////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////////////////////////

   initial begin
      reset    = 1'b1;
      bus.addr = 8'h00;
      bus.din  = 8'h00;
      bus.rdn  = 1'b1;                 // strobes idle high
      bus.wrn  = 1'b1;
      bus.cen  = 1'b1;
      bus.alen = 1'b0;
      void'($urandom(32'h73152615));
      repeat (16) @(posedge clk_usb);
      @(negedge clk_usb);
      reset = 1'b0;
      build_table();
      foreach (steps[n]) begin
         if (steps[n].idx == 8'd0)
            set_address(steps[n].addr);
         case (steps[n].op)
            op_write: begin
               bus_write(steps[n].data);
               check_value(8'(isout), 8'd0, $sformatf("step %0d isout after write", n));
            end
            op_read: begin
               bus_read(got, oe);
               check_value(got, steps[n].expected, $sformatf("step %0d read data", n));
               check_value(8'(oe), 8'd1, $sformatf("step %0d isout during read", n));
               check_value(8'(isout), steps[n].data, $sformatf("step %0d isout after read", n));
            end
            default: wait_fifo_count(steps[n].expected);
         endcase
      end
      $display("Test completed successfully");
      $finish;
   end

endmodule

// File: sim.f
+incdir+dv
source/usb_bus_pkg.sv
source/reg_map_pkg.sv
source/usb_reg_main.sv
source/reg_bank.sv
source/sample_gen.sv
source/sample_fifo.sv
source/usb_reg_top.sv
dv/usb_reg_tb.sv

// File: run_sim.sh
#!/bin/bash
# build and run the usb register bridge testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f sim.f --top-module usb_reg_tb -o usb_reg_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/usb_reg_sim
status=$?
if [ $status -ne 0 ]; then
   echo "simulation failed with status $status"
   exit $status
fi

exit 0
